/* myvision_pkg.sv */
package myvision_pkg;

	// Cartridge RAM geometry.
	localparam int RAM_AW = 15;
	localparam int DATA_W = 8;

	// Audio path.
	localparam int AUDIO_W = 10;
	localparam int DAC_W   = 16;

	// Console reset hold after a download or a menu reset.
	localparam int HOLD_CYCLES = 16;
	localparam int HOLD_CNT_W  = $clog2(HOLD_CYCLES);

	// Video path.
	localparam int COLOR_IN_W  = 8;
	localparam int COLOR_OUT_W = 6;

	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              we;
	} ram_req_t;

	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              we_n;  // Low for a write.
	} cpu_bus_t;

	typedef struct packed {
		logic [COLOR_IN_W-1:0] r;
		logic [COLOR_IN_W-1:0] g;
		logic [COLOR_IN_W-1:0] b;
		logic                  hs;
		logic                  vs;
		logic                  hb;
		logic                  vb;
	} video_in_t;

	typedef struct packed {
		logic [COLOR_OUT_W-1:0] r;
		logic [COLOR_OUT_W-1:0] g;
		logic [COLOR_OUT_W-1:0] b;
		logic                   hs;
		logic                   vs;
	} video_pin_t;

	typedef enum logic [1:0] {
		CTRL_BOOT,
		CTRL_LOAD,
		CTRL_HOLD,
		CTRL_RUN
	} ctrl_state_t;

endpackage

/* cart_ram.sv */
`timescale 1ns/10ps

module cart_ram (
	input  logic                            clk_sys_i,
	input  myvision_pkg::ram_req_t          req_i,
	output logic [myvision_pkg::DATA_W-1:0] rdata_o
);

	logic [myvision_pkg::DATA_W-1:0] mem [2**myvision_pkg::RAM_AW];

	// Read returns the old byte on a write to the same address.
	always_ff @(posedge clk_sys_i) begin
		if (req_i.we)
			mem[req_i.addr] <= req_i.wdata;
		rdata_o <= mem[req_i.addr];
	end

endmodule

/* sigma_delta_dac.sv */
`timescale 1ns/10ps

module sigma_delta_dac (
	input  logic                             clk_sys_i,
	input  logic                             rst_n_i,
	input  logic [myvision_pkg::AUDIO_W-1:0] audio_i,
	output logic                             dac_o
);

	localparam int PAD_W = myvision_pkg::DAC_W - myvision_pkg::AUDIO_W;

	logic [myvision_pkg::DAC_W-1:0] sample;
	logic [myvision_pkg::DAC_W-1:0] acc_q;
	logic                           carry_q;

	assign sample = {audio_i, PAD_W'(0)};  // Left aligned.

	always_ff @(posedge clk_sys_i) begin
		if (!rst_n_i) begin
			acc_q   <= '0;
			carry_q <= 1'b0;
		end else begin
			{carry_q, acc_q} <= {1'b0, acc_q} + {1'b0, sample};
		end
	end

	assign dac_o = carry_q;  // One bit per clock.

endmodule

/* spi_loader.sv */
`timescale 1ns/10ps

module spi_loader (
	input  logic                   clk_sys_i,
	input  logic                   rst_n_i,
	input  logic                   spi_sck_i,
	input  logic                   spi_ss2_i,
	input  logic                   spi_di_i,
	output logic                   loading_o,
	output myvision_pkg::ram_req_t load_req_o
);

	logic [2:0]                            sck_sync_q;  // Two sync stages plus history.
	logic [1:0]                            di_sync_q;
	logic [1:0]                            ss2_sync_q;
	logic                                  sck_rise;
	logic                                  in_frame;
	logic                                  byte_done;
	logic [$clog2(myvision_pkg::DATA_W)-1:0] bit_cnt_q;
	logic [myvision_pkg::DATA_W-2:0]       shift_q;
	logic [myvision_pkg::DATA_W-1:0]       byte_in;
	logic                                  first_byte_q;
	logic [myvision_pkg::DATA_W-1:0]       index_q;  // Image index of the current frame.
	logic [myvision_pkg::RAM_AW-1:0]       addr_cnt_q;
	logic                                  wr_q;
	logic [myvision_pkg::RAM_AW-1:0]       wr_addr_q;
	logic [myvision_pkg::DATA_W-1:0]       wr_data_q;

	assign sck_rise  = sck_sync_q[1] & ~sck_sync_q[2];
	assign in_frame  = ~ss2_sync_q[1];
	assign byte_in   = {shift_q, di_sync_q[1]};  // MSB first.
	assign byte_done = in_frame & sck_rise &
		(bit_cnt_q == ($clog2(myvision_pkg::DATA_W))'(myvision_pkg::DATA_W - 1));

	always_ff @(posedge clk_sys_i) begin
		if (!rst_n_i) begin
			sck_sync_q   <= '0;
			di_sync_q    <= '0;
			ss2_sync_q   <= '1;
			loading_o    <= 1'b0;
			bit_cnt_q    <= '0;
			first_byte_q <= 1'b1;
			addr_cnt_q   <= '0;
			wr_q         <= 1'b0;
		end else begin
			sck_sync_q <= {sck_sync_q[1:0], spi_sck_i};
			di_sync_q  <= {di_sync_q[0], spi_di_i};
			ss2_sync_q <= {ss2_sync_q[0], spi_ss2_i};
			loading_o  <= in_frame;
			wr_q       <= 1'b0;
			if (!in_frame) begin
				// Idle between frames.
				bit_cnt_q    <= '0;
				first_byte_q <= 1'b1;
				addr_cnt_q   <= '0;
			end else if (sck_rise) begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
			end
			if (byte_done) begin
				first_byte_q <= 1'b0;
				if (!first_byte_q) begin
					wr_q       <= 1'b1;
					addr_cnt_q <= addr_cnt_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys_i) begin
		if (sck_rise)
			shift_q <= byte_in[myvision_pkg::DATA_W-2:0];
		if (byte_done && first_byte_q)
			index_q <= byte_in;
		if (byte_done && !first_byte_q) begin
			wr_addr_q <= addr_cnt_q;
			wr_data_q <= byte_in;
		end
	end

	assign load_req_o = '{addr: wr_addr_q, wdata: wr_data_q, we: wr_q};

endmodule

/* load_ctrl.sv */
`timescale 1ns/10ps

module load_ctrl (
	input  logic                   clk_sys_i,
	input  logic                   rst_n_i,
	input  logic                   loading_i,
	input  logic                   menu_reset_i,
	input  myvision_pkg::ram_req_t load_req_i,
	input  myvision_pkg::cpu_bus_t cpu_bus_i,
	output myvision_pkg::ram_req_t ram_req_o,
	output logic                   console_reset_o,
	output logic                   led_o
);

	localparam logic [myvision_pkg::HOLD_CNT_W-1:0] HOLD_LAST =
		myvision_pkg::HOLD_CNT_W'(myvision_pkg::HOLD_CYCLES - 1);

	myvision_pkg::ctrl_state_t             state_q;
	logic [myvision_pkg::HOLD_CNT_W-1:0] hold_cnt_q;

	always_ff @(posedge clk_sys_i) begin
		if (!rst_n_i) begin
			state_q    <= myvision_pkg::CTRL_BOOT;
			hold_cnt_q <= HOLD_LAST;
		end else begin
			if (loading_i) begin
				state_q <= myvision_pkg::CTRL_LOAD;  // Any state.
			end else if (state_q == myvision_pkg::CTRL_LOAD) begin
				state_q    <= myvision_pkg::CTRL_HOLD;
				hold_cnt_q <= HOLD_LAST;
			end else if (menu_reset_i) begin
				// Hold restarts while the menu bit stays set.
				state_q    <= myvision_pkg::CTRL_HOLD;
				hold_cnt_q <= HOLD_LAST;
			end else begin
				case (state_q)
				myvision_pkg::CTRL_BOOT,
				myvision_pkg::CTRL_HOLD: begin
					if (hold_cnt_q == '0)
						state_q <= myvision_pkg::CTRL_RUN;
					else
						hold_cnt_q <= hold_cnt_q - 1'b1;
				end
				default: ;
				endcase
			end
		end
	end

	// RAM port owner.
	always_comb begin
		if (loading_i) begin
			ram_req_o = load_req_i;
		end else begin
			ram_req_o.addr  = cpu_bus_i.addr;
			ram_req_o.wdata = cpu_bus_i.wdata;
			ram_req_o.we    = (state_q == myvision_pkg::CTRL_RUN) & ~cpu_bus_i.we_n;
		end
	end

	assign console_reset_o = (state_q != myvision_pkg::CTRL_RUN);
	assign led_o           = ~loading_i;  // Lit while idle.

endmodule

/* video_out.sv */
`timescale 1ns/10ps

module video_out (
	input  logic                     clk_sys_i,
	input  logic                     rst_n_i,
	input  logic [1:0]               scanlines_i,
	input  myvision_pkg::video_in_t  video_i,
	output myvision_pkg::video_pin_t video_o
);

	localparam int CW = myvision_pkg::COLOR_OUT_W;

	myvision_pkg::video_pin_t vid_q;
	myvision_pkg::video_pin_t vid_d;
	logic                     blank;
	logic                     parity_q;
	logic                     parity_d;

	function automatic logic [CW-1:0] dim(input logic [CW-1:0] c, input logic [1:0] sel);
		case (sel)
		2'd1:    dim = c - (c >> 2);  // 25 percent.
		2'd2:    dim = c >> 1;
		2'd3:    dim = c >> 2;
		default: dim = c;
		endcase
	endfunction

	assign blank = video_i.hb | video_i.vb;

	// Previous syncs come from the output register.
	always_comb begin
		parity_d = parity_q;
		if (video_i.vs && !vid_q.vs)
			parity_d = 1'b0;
		else if (video_i.hs && !vid_q.hs)
			parity_d = ~parity_q;
	end

	always_comb begin
		vid_d.r  = blank ? '0 : video_i.r[myvision_pkg::COLOR_IN_W-1 -: CW];
		vid_d.g  = blank ? '0 : video_i.g[myvision_pkg::COLOR_IN_W-1 -: CW];
		vid_d.b  = blank ? '0 : video_i.b[myvision_pkg::COLOR_IN_W-1 -: CW];
		vid_d.hs = video_i.hs;
		vid_d.vs = video_i.vs;
		if (parity_d) begin
			vid_d.r = dim(vid_d.r, scanlines_i);
			vid_d.g = dim(vid_d.g, scanlines_i);
			vid_d.b = dim(vid_d.b, scanlines_i);
		end
	end

	always_ff @(posedge clk_sys_i) begin
		if (!rst_n_i) begin
			vid_q    <= '0;
			parity_q <= 1'b0;
		end else begin
			vid_q    <= vid_d;
			parity_q <= parity_d;
		end
	end

	assign video_o = vid_q;

endmodule

/* myvision_board.sv */
`timescale 1ns/10ps

module myvision_board (
	input  logic                             clk_sys_i,
	input  logic                             rst_n_i,
	// SPI download port.
	input  logic                             spi_sck_i,
	input  logic                             spi_ss2_i,
	input  logic                             spi_di_i,
	// Menu.
	input  logic                             menu_reset_i,
	input  logic [1:0]                       scanlines_i,
	// Console core side.
	input  myvision_pkg::cpu_bus_t           cpu_bus_i,
	output logic [myvision_pkg::DATA_W-1:0]  cpu_data_o,
	input  logic [myvision_pkg::AUDIO_W-1:0] audio_i,
	input  myvision_pkg::video_in_t          video_i,
	output logic                             console_reset_o,
	// Board side.
	output myvision_pkg::video_pin_t         video_o,
	output logic                             audio_l_o,
	output logic                             audio_r_o,
	output logic                             led_o
);

	logic                   loading;
	myvision_pkg::ram_req_t load_req;
	myvision_pkg::ram_req_t ram_req;

	spi_loader loader0 (
		.clk_sys_i  (clk_sys_i),
		.rst_n_i    (rst_n_i),
		.spi_sck_i  (spi_sck_i),
		.spi_ss2_i  (spi_ss2_i),
		.spi_di_i   (spi_di_i),
		.loading_o  (loading),
		.load_req_o (load_req)
	);

	load_ctrl ctrl0 (
		.clk_sys_i       (clk_sys_i),
		.rst_n_i         (rst_n_i),
		.loading_i       (loading),
		.menu_reset_i    (menu_reset_i),
		.load_req_i      (load_req),
		.cpu_bus_i       (cpu_bus_i),
		.ram_req_o       (ram_req),
		.console_reset_o (console_reset_o),
		.led_o           (led_o)
	);

	cart_ram ram0 (
		.clk_sys_i (clk_sys_i),
		.req_i     (ram_req),
		.rdata_o   (cpu_data_o)
	);

	sigma_delta_dac dac0 (
		.clk_sys_i (clk_sys_i),
		.rst_n_i   (rst_n_i),
		.audio_i   (audio_i),
		.dac_o     (audio_l_o)
	);

	assign audio_r_o = audio_l_o;  // Mono.

	video_out video0 (
		.clk_sys_i   (clk_sys_i),
		.rst_n_i     (rst_n_i),
		.scanlines_i (scanlines_i),
		.video_i     (video_i),
		.video_o     (video_o)
	);

endmodule

/* tb_myvision_board.sv */
`timescale 1ns/10ps

module tb_myvision_board;

	localparam int HOLD        = myvision_pkg::HOLD_CYCLES;
	localparam int CYCLE_LIMIT = 20000;  // Two downloads, DAC windows, video, margin.

	logic                     clk_sys = 1'b0;
	logic                     rst_n;
	logic                     spi_sck;
	logic                     spi_ss2;
	logic                     spi_di;
	logic                     menu_reset;
	logic [1:0]               scanlines;
	myvision_pkg::cpu_bus_t   cpu_bus;
	logic [7:0]               cpu_data_o;
	logic [9:0]               audio;
	myvision_pkg::video_in_t  video;
	logic                     console_reset_o;
	myvision_pkg::video_pin_t video_o;
	logic                     audio_l_o;
	logic                     audio_r_o;
	logic                     led_o;

	integer     seed;
	int         cycles = 0;
	int         test_errs = 0;
	int         pass_cnt = 0;
	int         fail_cnt = 0;
	logic       dl_started = 1'b0;
	logic [7:0] image [64];  // Copy of the downloaded bytes.

	myvision_board dut0 (
		.clk_sys_i       (clk_sys),
		.rst_n_i         (rst_n),
		.spi_sck_i       (spi_sck),
		.spi_ss2_i       (spi_ss2),
		.spi_di_i        (spi_di),
		.menu_reset_i    (menu_reset),
		.scanlines_i     (scanlines),
		.cpu_bus_i       (cpu_bus),
		.cpu_data_o      (cpu_data_o),
		.audio_i         (audio),
		.video_i         (video),
		.console_reset_o (console_reset_o),
		.video_o         (video_o),
		.audio_l_o       (audio_l_o),
		.audio_r_o       (audio_r_o),
		.led_o           (led_o)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the run did not complete", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
			test_errs++;
		end
	endtask

	task automatic check_range(input string name, input int lo, input int hi, input int got);
		assert (got >= lo && got <= hi) else begin
			$display("ERR %0t %s expected %0d..%0d got %0d", $time, name, lo, hi, got);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0)
			pass_cnt++;
		else
			fail_cnt++;
		$display("test %s: %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed", test_errs);
		test_errs = 0;
	endtask

	// Mono DAC output.
	assert property (@(posedge clk_sys) disable iff (!rst_n) audio_r_o == audio_l_o)
		else begin
			$display("ERR %0t audio_r_o expected %0h got %0h", $time,
				$sampled(audio_l_o), $sampled(audio_r_o));
			test_errs++;
		end

	// No write while the console is held in reset before the first download.
	always @(negedge clk_sys) begin
		if (!dl_started && console_reset_o)
			check_eq("ram_req.we", 0, dut0.ram_req.we);
	end

	// Counts negedges, this one included, with the console held in reset.
	task automatic measure_reset(output int n);
		n = 0;
		while (console_reset_o && n < 200) begin
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic spi_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_sck = 1'b0;
			spi_di  = b[i];  // MSB first.
			repeat (4) @(negedge clk_sys);
			spi_sck = 1'b1;
			repeat (4) @(negedge clk_sys);
			check_eq("led_o", 0, led_o);
			check_eq("console_reset_o", 1, console_reset_o);
		end
	endtask

	task automatic download(input int n, input logic [7:0] idx, input logic cpu_wr);
		int hi;
		dl_started = 1'b1;
		spi_ss2    = 1'b0;
		repeat (4) @(negedge clk_sys);
		if (cpu_wr)
			cpu_bus.we_n = 1'b0;  // CPU tries to write while the loader owns the RAM.
		spi_byte(idx);
		for (int i = 0; i < n; i++)
			spi_byte(image[i]);
		spi_sck = 1'b0;
		@(negedge clk_sys);
		cpu_bus.we_n = 1'b1;
		@(negedge clk_sys);
		spi_ss2 = 1'b1;
		// Hold is counted from the falling loading level.
		while (!led_o)
			@(negedge clk_sys);
		measure_reset(hi);
		check_range("console_reset_o high cycles", HOLD + 1, HOLD + 2, hi);
	endtask

	task automatic readback(input int n);
		cpu_bus.we_n = 1'b1;
		for (int i = 0; i < n; i++) begin
			cpu_bus.addr = i;
			@(negedge clk_sys);
			check_eq("cpu_data_o", image[i], cpu_data_o);
		end
	endtask

	task automatic cpu_write(input logic [14:0] addr, input logic [7:0] data);
		cpu_bus.addr  = addr;
		cpu_bus.wdata = data;
		cpu_bus.we_n  = 1'b0;
		@(negedge clk_sys);
		cpu_bus.we_n  = 1'b1;
	endtask

	task automatic cpu_read(input logic [14:0] addr, output logic [7:0] data);
		cpu_bus.addr = addr;
		cpu_bus.we_n = 1'b1;
		@(negedge clk_sys);
		data = cpu_data_o;
	endtask

	task automatic audio_window(input logic [9:0] s);
		int ones;
		int exp_ones;
		ones     = 0;
		exp_ones = (1024 * (int'(s) << (myvision_pkg::DAC_W - myvision_pkg::AUDIO_W)))
			/ (1 << myvision_pkg::DAC_W);
		audio = s;
		repeat (1024) begin
			@(negedge clk_sys);
			ones += audio_l_o;
		end
		check_range("audio_l_o ones", exp_ones - 1, exp_ones + 1, ones);
	endtask

	function automatic logic [5:0] channel_expect(input logic [7:0] c, input logic [1:0] sl,
			input logic odd, input logic blank);
		logic [5:0] t;
		t = blank ? 6'd0 : c[7:2];
		if (odd) begin
			case (sl)
			2'd1: t = t - t / 4;
			2'd2: t = t / 2;
			2'd3: t = t / 4;
			default: ;
			endcase
		end
		return t;
	endfunction

	task automatic video_sweep();
		myvision_pkg::video_pin_t exp;
		logic have_exp;
		logic odd;
		logic prev_hs;
		logic prev_vs;
		logic blank;
		have_exp = 1'b0;
		odd      = 1'b0;
		prev_hs  = 1'b0;
		prev_vs  = 1'b0;
		for (int sl = 0; sl < 4; sl++) begin
			for (int line = 0; line < 4; line++) begin
				for (int px = 0; px < 8; px++) begin
					if (have_exp)
						check_eq("video_o", exp, video_o);
					video.hs  = (px == 0);
					video.vs  = (line == 0 && px < 2);
					video.hb  = (px < 2);
					video.vb  = (line == 0);
					video.r   = $random(seed);
					video.g   = $random(seed);
					video.b   = $random(seed);
					scanlines = sl;
					if (video.vs && !prev_vs)
						odd = 1'b0;
					else if (video.hs && !prev_hs)
						odd = ~odd;
					prev_hs  = video.hs;
					prev_vs  = video.vs;
					blank    = video.hb | video.vb;
					exp.r    = channel_expect(video.r, sl, odd, blank);
					exp.g    = channel_expect(video.g, sl, odd, blank);
					exp.b    = channel_expect(video.b, sl, odd, blank);
					exp.hs   = video.hs;
					exp.vs   = video.vs;
					have_exp = 1'b1;
					@(negedge clk_sys);
				end
			end
		end
		check_eq("video_o", exp, video_o);
	endtask

	initial begin
		int         n;
		logic [7:0] idx;
		logic [7:0] d;
		seed       = 32'h0813_2b93;
		rst_n      = 1'b0;
		spi_sck    = 1'b0;
		spi_ss2    = 1'b1;
		spi_di     = 1'b0;
		menu_reset = 1'b0;
		scanlines  = 2'd0;
		cpu_bus    = '{addr: '0, wdata: '0, we_n: 1'b0};  // CPU writes while held in reset.
		audio      = '0;
		video      = '0;
		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;

		check_eq("console_reset_o", 1, console_reset_o);
		check_eq("led_o", 1, led_o);
		measure_reset(n);
		cpu_bus.we_n = 1'b1;
		check_range("console_reset_o high cycles", HOLD, HOLD + 2, n);
		repeat (20) @(negedge clk_sys);
		end_test("reset");

		for (int i = 0; i < 64; i++)
			image[i] = $random(seed);
		idx = ~image[0];  // Never equal to the first data byte.
		download(64, idx, 1'b0);
		end_test("download");

		readback(64);
		cpu_read(15'h0000, d);
		assert (d != idx) else begin
			$display("Index byte was written to address 0");
			test_errs++;
		end
		end_test("readback");

		cpu_write(15'h0100, 8'ha5);
		cpu_read(15'h0100, d);
		check_eq("cpu_data_o", 8'ha5, d);
		cpu_bus.addr  = 15'h0100;
		cpu_bus.wdata = 8'h3c;
		for (int i = 0; i < 16; i++)
			image[i] = $random(seed);
		download(16, 8'h02, 1'b1);
		readback(16);
		cpu_read(15'h0100, d);
		check_eq("cpu_data_o", 8'ha5, d);
		end_test("cpu write");

		menu_reset = 1'b1;
		repeat (3) @(negedge clk_sys);
		check_eq("console_reset_o", 1, console_reset_o);
		menu_reset = 1'b0;
		measure_reset(n);
		check_range("console_reset_o high cycles", HOLD, HOLD + 4, n);
		end_test("menu reset");

		audio_window(10'h200);
		audio_window(10'h080);
		end_test("audio");

		video_sweep();
		end_test("video");

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sim.f */
myvision_pkg.sv
cart_ram.sv
sigma_delta_dac.sv
spi_loader.sv
load_ctrl.sv
video_out.sv
myvision_board.sv
tb_myvision_board.sv

/* Bender.yml */
package:
  name: myvision_board

sources:
  - myvision_pkg.sv
  - cart_ram.sv
  - sigma_delta_dac.sv
  - spi_loader.sv
  - load_ctrl.sv
  - video_out.sv
  - myvision_board.sv
  - target: simulation
    files:
      - tb_myvision_board.sv
